// File: tb.f
rtl/cp15Pkg.sv
rtl/cp15Arbiter.sv
rtl/cp15RequestLatch.sv
rtl/cp15RegFile.sv
rtl/cp15MaintDecoder.sv
rtl/cp15Top.sv
tests/cp15Handshake_properties.sv
tests/cp15Tb.sv

// File: Makefile
# Verilator build for the CP15 coprocessor testbench

VERILATOR ?= verilator
TOP       ?= cp15Tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/cp15Tb.sv
`timescale 1ns/10ps

module cp15Tb import cp15Pkg::*; ();

  localparam int TIMEOUT_CYCLES = 32;

  logic        clk = 1'b0;
  logic        reset;
  logic        cpuReq;
  logic        cpuWrite;
  regAddr      cpuAddr;
  cp15Word     cpuWdata;
  opcode2Field cpuOpcode2;
  crmField     cpuCrm;
  logic        cpuAck;
  logic        mmuReq;
  logic        mmuWrite;
  regAddr      mmuAddr;
  cp15Word     mmuWdata;
  logic        mmuAck;
  cp15Word     rdata;
  cp15Word     control;
  logic        flushI;
  logic        flushD;
  logic        cleanI;
  logic        cleanD;
  logic        tlbFlushI;
  logic        tlbFlushD;
  maintOps     seenOps;

  // Reference register contents and round-robin history
  cp15Word     model [NUM_REGS];
  logic [31:0] rngState;
  logic        lastMmu;

  always #4 clk = ~clk;

  cp15Top uut (.*);

  assign seenOps = {flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD};

  // **************************************************
  // Reference model
  // **************************************************

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic cp15Word modelRead(input regAddr addr);
    return (addr == REG_ID) ? CP15_ID : model[addr];
  endfunction

  // Pulses in the order flushI flushD cleanI cleanD tlbFlushI tlbFlushD
  function automatic maintOps expectedOps(input logic isMmu, input logic write,
      input regAddr addr, input opcode2Field op2, input crmField crm);
    maintOps ops;
    ops = '0;
    if (!isMmu && write && op2 <= 3'd1) begin
      if (addr == REG_CACHE_OPS) begin
        case (crm)
          4'd7:  ops = 6'b110000;
          4'd5:  ops = 6'b100000;
          4'd6:  ops = 6'b010000;
          4'd11: ops = 6'b001100;
          4'd10: ops = 6'b000100;
          4'd15: ops = 6'b111100;
          4'd14: ops = 6'b010100;
          default: ops = '0;
        endcase
      end else if (addr == REG_TLB_OPS) begin
        case (crm)
          4'd7: ops = 6'b000011;
          4'd5: ops = 6'b000010;
          4'd6: ops = 6'b000001;
          default: ops = '0;
        endcase
      end
    end
    return ops;
  endfunction

  // **************************************************
  // Compare tasks
  // **************************************************

  task automatic abortRun();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input cp15Word got, input cp15Word expected);
    if (got !== expected) begin
      $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, expected);
      abortRun();
    end
  endtask

  task automatic checkOps(input maintOps got, input maintOps expected);
    if (got !== expected) begin
      $display("FAILED at %0d ns: maint pulses = %b, expected %b", $time, got, expected);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("FAILED at %0d ns: %s = %b, expected %b", $time, name, got, expected);
      abortRun();
    end
  endtask

  // **************************************************
  // Handshake tasks
  // **************************************************

  task automatic applyReset();
    reset  <= 1'b1;
    cpuReq <= 1'b0;
    mmuReq <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
    end
    // CPU has priority first
    lastMmu = 1'b1;
    @(negedge clk);
  endtask

  task automatic driveRequest(input logic isMmu, input logic write, input regAddr addr,
      input cp15Word data, input opcode2Field op2, input crmField crm);
    if (isMmu) begin
      mmuReq   <= 1'b1;
      mmuWrite <= write;
      mmuAddr  <= addr;
      mmuWdata <= data;
    end else begin
      cpuReq     <= 1'b1;
      cpuWrite   <= write;
      cpuAddr    <= addr;
      cpuWdata   <= data;
      cpuOpcode2 <= op2;
      cpuCrm     <= crm;
    end
  endtask

  task automatic waitAck(input logic isMmu, input logic level);
    int cycles;
    cycles = 0;
    while ((isMmu ? mmuAck : cpuAck) !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: %s ack did not go %s", isMmu ? "MMU" : "CPU",
                 level ? "high" : "low");
        abortRun();
      end
    end
  endtask

  task automatic waitAnyAck();
    int cycles;
    cycles = 0;
    while (!(cpuAck || mmuAck)) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: neither port was acknowledged");
        abortRun();
      end
    end
  endtask

  // Called in the first cycle with ack high
  task automatic finishAccess(input logic isMmu, input logic write, input regAddr addr,
      input cp15Word data, input opcode2Field op2, input crmField crm);
    cp15Word expRead;
    expRead = modelRead(addr);
    checkOps(seenOps, expectedOps(isMmu, write, addr, op2, crm));
    if (write) begin
      if (addr != REG_ID) model[addr] = data;
    end else begin
      checkWord("rdata", rdata, expRead);
    end
    checkWord("control", control, model[REG_CONTROL]);
    @(posedge clk);
    if (isMmu) mmuReq <= 1'b0;
    else cpuReq <= 1'b0;
    @(negedge clk);
    // Pulses last one cycle and rdata holds while ack is high
    checkOps(seenOps, '0);
    if (!write) checkWord("rdata", rdata, expRead);
    waitAck(isMmu, 1'b0);
    lastMmu = isMmu;
  endtask

  task automatic runSingle(input logic isMmu, input logic write, input regAddr addr,
      input cp15Word data, input opcode2Field op2, input crmField crm);
    @(posedge clk);
    driveRequest(isMmu, write, addr, data, op2, crm);
    waitAck(isMmu, 1'b1);
    finishAccess(isMmu, write, addr, data, op2, crm);
  endtask

  // Both ports raise req on the same edge
  task automatic runDual();
    logic        wr [2];
    regAddr      ad [2];
    cp15Word     dt [2];
    opcode2Field o2 [2];
    crmField     cm [2];
    logic [31:0] r;
    logic        winner;
    for (int p = 0; p < 2; p++) begin
      r = nextRandom();
      wr[p] = r[0];
      ad[p] = r[4:1];
      o2[p] = (p == 0) ? r[7:5] : 3'd0;
      cm[p] = (p == 0) ? r[11:8] : 4'd0;
      dt[p] = nextRandom();
    end
    @(posedge clk);
    driveRequest(1'b0, wr[0], ad[0], dt[0], o2[0], cm[0]);
    driveRequest(1'b1, wr[1], ad[1], dt[1], o2[1], cm[1]);
    waitAnyAck();
    winner = mmuAck;
    checkFlag("mmuAck", winner, ~lastMmu);
    finishAccess(winner, wr[winner], ad[winner], dt[winner], o2[winner], cm[winner]);
    waitAck(~winner, 1'b1);
    finishAccess(~winner, wr[~winner], ad[~winner], dt[~winner], o2[~winner], cm[~winner]);
  endtask

  // **************************************************
  // Stimulus
  // **************************************************

  initial begin
    logic [31:0] r;
    cp15Word     d;
    opcode2Field op2;
    reset      = 1'b1;
    cpuReq     = 1'b0;
    cpuWrite   = 1'b0;
    cpuAddr    = '0;
    cpuWdata   = '0;
    cpuOpcode2 = '0;
    cpuCrm     = '0;
    mmuReq     = 1'b0;
    mmuWrite   = 1'b0;
    mmuAddr    = '0;
    mmuWdata   = '0;
    rngState   = 32'h4c35_5917;
    applyReset();

    // Reset values
    checkWord("control", control, '0);
    checkWord("rdata", rdata, '0);
    for (int a = 0; a < NUM_REGS; a++) begin
      runSingle(a[0], 1'b0, regAddr'(a), '0, '0, '0);
    end

    // Random traffic from both ports
    repeat (300) begin
      r = nextRandom();
      d = nextRandom();
      runSingle(r[0], r[1], r[5:2], d, r[8:6], r[12:9]);
    end

    // Register 0 is read-only
    for (int p = 0; p < 2; p++) begin
      d = nextRandom();
      runSingle(p[0], 1'b1, REG_ID, d, '0, '0);
      runSingle(p[0], 1'b0, REG_ID, '0, '0, '0);
    end

    // Cache and TLB maintenance with opcode2 biased toward 0 and 1
    repeat (120) begin
      r = nextRandom();
      d = nextRandom();
      op2 = r[3] ? r[2:0] : {2'b00, r[0]};
      runSingle(1'b0, 1'b1, r[8] ? REG_TLB_OPS : REG_CACHE_OPS, d, op2, r[7:4]);
    end

    // MMU writes never pulse
    repeat (20) begin
      r = nextRandom();
      d = nextRandom();
      runSingle(1'b1, 1'b1, r[0] ? REG_TLB_OPS : REG_CACHE_OPS, d, '0, '0);
    end

    // Arbitration order from a fresh reset
    applyReset();
    runDual();

    // A single access from either port moves the priority
    for (int i = 0; i < 11; i++) begin
      d = nextRandom();
      runSingle(i[0], 1'b0, d[3:0], '0, '0, '0);
      runDual();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// File: tests/cp15Handshake_properties.sv
`timescale 1ns/10ps

module cp15HandshakeProperties (
  input logic clk,
  input logic reset,
  input logic cpuReq,
  input logic mmuReq,
  input logic cpuAck,
  input logic mmuAck,
  input logic flushI,
  input logic flushD,
  input logic cleanI,
  input logic cleanD,
  input logic tlbFlushI,
  input logic tlbFlushD
);

  logic anyPulse;

  assign anyPulse = flushI | flushD | cleanI | cleanD | tlbFlushI | tlbFlushD;

  // Ack only answers a pending request
  cpuAckNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(cpuAck) |-> cpuReq)
    else $error("cpuAck rose while cpuReq was low");

  mmuAckNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(mmuAck) |-> mmuReq)
    else $error("mmuAck rose while mmuReq was low");

  acksExclusive: assert property (@(posedge clk) disable iff (reset) !(cpuAck && mmuAck))
    else $error("cpuAck and mmuAck high together");

  // Pulses line up with the first ack cycle and last one cycle
  pulseOnAckRise: assert property (@(posedge clk) disable iff (reset)
      anyPulse |-> ($rose(cpuAck) || $rose(mmuAck)))
    else $error("maintenance pulse outside the first ack cycle");

  pulseOneCycle: assert property (@(posedge clk) disable iff (reset) anyPulse |=> !anyPulse)
    else $error("maintenance pulse longer than one cycle");

endmodule

bind cp15Top cp15HandshakeProperties handshakeProps (
  .clk       (clk),
  .reset     (reset),
  .cpuReq    (cpuReq),
  .mmuReq    (mmuReq),
  .cpuAck    (cpuAck),
  .mmuAck    (mmuAck),
  .flushI    (flushI),
  .flushD    (flushD),
  .cleanI    (cleanI),
  .cleanD    (cleanD),
  .tlbFlushI (tlbFlushI),
  .tlbFlushD (tlbFlushD)
);

// File: rtl/cp15Top.sv
`timescale 1ns/10ps

module cp15Top import cp15Pkg::*; (
  input  logic        clk,
  input  logic        reset,
  // CPU port
  input  logic        cpuReq,
  input  logic        cpuWrite,
  input  regAddr      cpuAddr,
  input  cp15Word     cpuWdata,
  input  opcode2Field cpuOpcode2,
  input  crmField     cpuCrm,
  output logic        cpuAck,
  // MMU port
  input  logic        mmuReq,
  input  logic        mmuWrite,
  input  regAddr      mmuAddr,
  input  cp15Word     mmuWdata,
  output logic        mmuAck,
  // Shared outputs
  output cp15Word     rdata,
  output cp15Word     control,
  output logic        flushI,
  output logic        flushD,
  output logic        cleanI,
  output logic        cleanD,
  output logic        tlbFlushI,
  output logic        tlbFlushD
);

  logic        capture;
  logic        grantMmu;
  logic        accessEn;
  logic        lWrite;
  regAddr      lAddr;
  cp15Word     lWdata;
  opcode2Field lOpcode2;
  crmField     lCrm;
  maintOps     ops;

  // **************************************************
  // Control and datapath
  // **************************************************

  cp15Arbiter arbiter (
    .clk      (clk),
    .reset    (reset),
    .cpuReq   (cpuReq),
    .mmuReq   (mmuReq),
    .capture  (capture),
    .grantMmu (grantMmu),
    .accessEn (accessEn),
    .cpuAck   (cpuAck),
    .mmuAck   (mmuAck)
  );

  cp15RequestLatch requestLatch (
    .clk        (clk),
    .reset      (reset),
    .capture    (capture),
    .grantMmu   (grantMmu),
    .cpuWrite   (cpuWrite),
    .cpuAddr    (cpuAddr),
    .cpuWdata   (cpuWdata),
    .cpuOpcode2 (cpuOpcode2),
    .cpuCrm     (cpuCrm),
    .mmuWrite   (mmuWrite),
    .mmuAddr    (mmuAddr),
    .mmuWdata   (mmuWdata),
    .lWrite     (lWrite),
    .lAddr      (lAddr),
    .lWdata     (lWdata),
    .lOpcode2   (lOpcode2),
    .lCrm       (lCrm)
  );

  cp15RegFile regFile (
    .clk      (clk),
    .reset    (reset),
    .accessEn (accessEn),
    .lWrite   (lWrite),
    .lAddr    (lAddr),
    .lWdata   (lWdata),
    .rdata    (rdata),
    .control  (control)
  );

  cp15MaintDecoder maintDecoder (
    .clk      (clk),
    .reset    (reset),
    .accessEn (accessEn),
    .lWrite   (lWrite),
    .lAddr    (lAddr),
    .lOpcode2 (lOpcode2),
    .lCrm     (lCrm),
    .ops      (ops)
  );

  // Pulse outputs in maintOps bit order
  assign {flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD} = ops;

endmodule

// File: rtl/cp15MaintDecoder.sv
`timescale 1ns/10ps

module cp15MaintDecoder import cp15Pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        accessEn,
  input  logic        lWrite,
  input  regAddr      lAddr,
  input  opcode2Field lOpcode2,
  input  crmField     lCrm,
  output maintOps     ops
);

  logic    opValid;
  maintOps opsNext;

  // Only writes with opcode2 0 or 1 trigger maintenance
  assign opValid = accessEn & lWrite & (lOpcode2[2:1] == 2'b00);

  // **************************************************
  // Decode tables
  // **************************************************

  always_comb begin
    opsNext = '0;
    if (opValid) begin
      if (lAddr == REG_CACHE_OPS) begin
        // flushI flushD cleanI cleanD
        case (lCrm)
          4'd7:    opsNext[5:2] = 4'b1100;
          4'd5:    opsNext[5:2] = 4'b1000;
          4'd6:    opsNext[5:2] = 4'b0100;
          4'd11:   opsNext[5:2] = 4'b0011;
          4'd10:   opsNext[5:2] = 4'b0001;
          4'd15:   opsNext[5:2] = 4'b1111;
          4'd14:   opsNext[5:2] = 4'b0101;
          default: opsNext[5:2] = 4'b0000;
        endcase
      end else if (lAddr == REG_TLB_OPS) begin
        // tlbFlushI tlbFlushD
        case (lCrm)
          4'd7:    opsNext[1:0] = 2'b11;
          4'd5:    opsNext[1:0] = 2'b10;
          4'd6:    opsNext[1:0] = 2'b01;
          default: opsNext[1:0] = 2'b00;
        endcase
      end
    end
  end

  // One-cycle pulse in the first ack cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      ops <= '0;
    end else begin
      ops <= opsNext;
    end
  end

endmodule

// File: rtl/cp15RegFile.sv
`timescale 1ns/10ps

module cp15RegFile import cp15Pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    accessEn,
  input  logic    lWrite,
  input  regAddr  lAddr,
  input  cp15Word lWdata,
  output cp15Word rdata,
  output cp15Word control
);

  // Register 0 is a constant, so storage starts at 1
  cp15Word regs [1:NUM_REGS-1];

  // **************************************************
  // Register write
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (accessEn && lWrite && (lAddr != REG_ID)) begin
      regs[lAddr] <= lWdata;
    end
  end

  // **************************************************
  // Registered read
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (accessEn && !lWrite) begin
      if (lAddr == REG_ID) begin
        rdata <= CP15_ID;
      end else begin
        rdata <= regs[lAddr];
      end
    end
  end

  // Control register is always visible
  assign control = regs[REG_CONTROL];

endmodule

// File: rtl/cp15RequestLatch.sv
`timescale 1ns/10ps

module cp15RequestLatch import cp15Pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        capture,
  input  logic        grantMmu,
  input  logic        cpuWrite,
  input  regAddr      cpuAddr,
  input  cp15Word     cpuWdata,
  input  opcode2Field cpuOpcode2,
  input  crmField     cpuCrm,
  input  logic        mmuWrite,
  input  regAddr      mmuAddr,
  input  cp15Word     mmuWdata,
  output logic        lWrite,
  output regAddr      lAddr,
  output cp15Word     lWdata,
  output opcode2Field lOpcode2,
  output crmField     lCrm
);

  // Read or write flag of the granted port
  always_ff @(posedge clk) begin
    if (reset) begin
      lWrite <= 1'b0;
    end else if (capture) begin
      lWrite <= grantMmu ? mmuWrite : cpuWrite;
    end
  end

  // Payload fields of the granted port
  always_ff @(posedge clk) begin
    if (capture) begin
      if (grantMmu) begin
        lAddr    <= mmuAddr;
        lWdata   <= mmuWdata;
        // MMU never issues maintenance encodings
        lOpcode2 <= '0;
        lCrm     <= '0;
      end else begin
        lAddr    <= cpuAddr;
        lWdata   <= cpuWdata;
        lOpcode2 <= cpuOpcode2;
        lCrm     <= cpuCrm;
      end
    end
  end

endmodule

// File: rtl/cp15Arbiter.sv
`timescale 1ns/10ps

module cp15Arbiter import cp15Pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic cpuReq,
  input  logic mmuReq,
  output logic capture,
  output logic grantMmu,
  output logic accessEn,
  output logic cpuAck,
  output logic mmuAck
);

  arbState state;
  arbState nextState;

  // Round-robin priority flag that starts with the CPU
  logic mmuFirst;
  logic grantSel;
  logic grantReg;
  logic grantedReq;
  logic anyReq;

  // **************************************************
  // Grant selection
  // **************************************************

  assign anyReq = cpuReq | mmuReq;

  // MMU wins when alone, or when both wait and it is its turn
  assign grantSel = mmuReq & (~cpuReq | mmuFirst);

  // Request line of whoever owns the current transaction
  assign grantedReq = grantReg ? mmuReq : cpuReq;

  // **************************************************
  // Handshake FSM
  // **************************************************

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (anyReq) nextState = ACCESS;
      end
      ACCESS: begin
        nextState = ACKING;
      end
      ACKING: begin
        // Hold ack until the owner drops req
        if (!grantedReq) nextState = IDLE;
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      mmuFirst <= 1'b0;
      grantReg <= 1'b0;
    end else begin
      state <= nextState;
      if (capture) begin
        grantReg <= grantSel;
        // The one not served gets priority next time
        mmuFirst <= ~grantSel;
      end
    end
  end

  assign capture  = (state == IDLE) & anyReq;
  assign grantMmu = (state == IDLE) ? grantSel : grantReg;
  assign accessEn = (state == ACCESS);

  // Acks follow the registered grant
  assign cpuAck = (state == ACKING) & ~grantReg;
  assign mmuAck = (state == ACKING) & grantReg;

endmodule

// File: rtl/cp15Pkg.sv
package cp15Pkg;

  // **************************************************
  // Widths
  // **************************************************

  typedef logic [31:0] cp15Word;
  typedef logic [3:0]  regAddr;
  typedef logic [2:0]  opcode2Field;
  typedef logic [3:0]  crmField;

  // flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD (MSB first)
  typedef logic [5:0]  maintOps;

  // **************************************************
  // Register map
  // **************************************************

  localparam int NUM_REGS = 16;

  localparam regAddr REG_ID        = 4'd0;
  localparam regAddr REG_CONTROL   = 4'd1;
  localparam regAddr REG_CACHE_OPS = 4'd7;
  localparam regAddr REG_TLB_OPS   = 4'd8;

  // Identification word returned by register 0
  localparam cp15Word CP15_ID = 32'h5C15_0A01;

  // Arbiter FSM
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACKING
  } arbState;

endpackage
